// ==== Bender.yml ====
package:
  name: ht_node_ctrl

sources:
  - design/stream_pkg.sv
  - design/ctrl_pkg.sv
  - design/beat_if.sv
  - design/por_reset_gen.sv
  - design/rx_link_watchdog.sv
  - design/tx_node_mux.sv
  - design/rx_type_dispatch.sv
  - design/ht_top.sv
  - target: test
    files:
      - tb/ht_top_tb.sv

// ==== all.f ====
design/stream_pkg.sv
design/ctrl_pkg.sv
design/beat_if.sv
design/por_reset_gen.sv
design/rx_link_watchdog.sv
design/tx_node_mux.sv
design/rx_type_dispatch.sv
design/ht_top.sv
tb/ht_top_tb.sv

// ==== design/beat_if.sv ====
/*
 * one stream beat
 * valid strobe with data, last and byte enables, no ready
 */
`default_nettype none

interface beat_if import stream_pkg::*; ();

  logic              valid;  // one-cycle strobe per beat
  logic [DATA_W-1:0] data;
  logic              last;   // final beat of a frame
  logic [KEEP_W-1:0] keep;

  modport src (output valid, output data, output last, output keep);
  modport snk (input valid, input data, input last, input keep);

endinterface

`default_nettype wire

// ==== design/ctrl_pkg.sv ====
/*
 * node control constants
 * node_info field layout, power-up reset timing and receive watchdog
 * timing and state codes
 */
`default_nettype none

package ctrl_pkg;

  // node_info = {node id, slot mask}
  localparam int NODE_W      = 8;
  localparam int NODE_ID_LSB = 4;   // node id in bits 7:4
  localparam int SLOT_W      = 4;   // slot mask in bits 3:0
  localparam int ETH_SLOT    = 0;   // ethernet slot enable bit

  //******************************
  // reset and watchdog timing
  //******************************
  localparam int RST_CNT_W = 7;
  localparam logic [RST_CNT_W-1:0] RST_RELEASE_COUNT = 7'd32;

  localparam int WD_CNT_W = 7;
  localparam logic [WD_CNT_W-1:0] WD_WAIT_CYCLES = 7'd64; // scaled down for sim

  // watchdog FSM state codes
  localparam int WD_ST_W = 3;
  localparam logic [WD_ST_W-1:0] WD_ST_WAIT    = 3'd0;
  localparam logic [WD_ST_W-1:0] WD_ST_PULSE   = 3'd1;
  localparam logic [WD_ST_W-1:0] WD_ST_RETRY   = 3'd2;
  localparam logic [WD_ST_W-1:0] WD_ST_SETTLE  = 3'd3;
  localparam logic [WD_ST_W-1:0] WD_ST_REWAIT  = 3'd4;
  localparam logic [WD_ST_W-1:0] WD_ST_MONITOR = 3'd5;

endpackage

`default_nettype wire

// ==== design/ht_top.sv ====
/*
 * hybrid transport node, control top level
 * power-up reset, rx watchdog, transmit mux and receive dispatch
 */
`default_nettype none

module ht_top
  import stream_pkg::*;
  import ctrl_pkg::*;
(
  input  logic              dclk,
  input  logic              sys_rst_n,
  input  logic              locked,
  input  logic              stat_rx_status,
  input  logic [NODE_W-1:0] node_info,
  input  logic              eth_in_valid,   // ethernet branch stream
  input  logic [DATA_W-1:0] eth_in_data,
  input  logic              eth_in_last,
  input  logic [KEEP_W-1:0] eth_in_keep,
  input  logic              sfp_in_valid,   // from the 10G link
  input  logic [DATA_W-1:0] sfp_in_data,
  input  logic              sfp_in_last,
  input  logic [KEEP_W-1:0] sfp_in_keep,
  output logic              link_rst_n,
  output logic              rx_datapath_reset,
  output logic              sfp_out_valid,  // toward the 10G link
  output logic [DATA_W-1:0] sfp_out_data,
  output logic              sfp_out_last,
  output logic [KEEP_W-1:0] sfp_out_keep,
  output logic              eth_out_valid,  // back to the ethernet branch
  output logic [DATA_W-1:0] eth_out_data,
  output logic              eth_out_last,
  output logic [KEEP_W-1:0] eth_out_keep
);

  beat_if eth_in ();
  beat_if sfp_out ();
  beat_if sfp_in ();
  beat_if eth_out ();

  // ports onto the input streams
  assign eth_in.valid = eth_in_valid;
  assign eth_in.data  = eth_in_data;
  assign eth_in.last  = eth_in_last;
  assign eth_in.keep  = eth_in_keep;
  assign sfp_in.valid = sfp_in_valid;
  assign sfp_in.data  = sfp_in_data;
  assign sfp_in.last  = sfp_in_last;
  assign sfp_in.keep  = sfp_in_keep;

  // output streams back to ports
  assign sfp_out_valid = sfp_out.valid;
  assign sfp_out_data  = sfp_out.data;
  assign sfp_out_last  = sfp_out.last;
  assign sfp_out_keep  = sfp_out.keep;
  assign eth_out_valid = eth_out.valid;
  assign eth_out_data  = eth_out.data;
  assign eth_out_last  = eth_out.last;
  assign eth_out_keep  = eth_out.keep;

  por_reset_gen u_por_reset_gen (
    .dclk       (dclk),
    .sys_rst_n  (sys_rst_n),
    .locked     (locked),
    .link_rst_n (link_rst_n)
  );

  rx_link_watchdog u_rx_link_watchdog (
    .dclk              (dclk),
    .sys_rst_n         (sys_rst_n),
    .link_rst_n        (link_rst_n),
    .stat_rx_status    (stat_rx_status),
    .rx_datapath_reset (rx_datapath_reset)
  );

  tx_node_mux u_tx_node_mux (
    .dclk      (dclk),
    .sys_rst_n (sys_rst_n),
    .node_info (node_info),
    .eth_in    (eth_in.snk),
    .sfp_out   (sfp_out.src)
  );

  rx_type_dispatch u_rx_type_dispatch (
    .dclk      (dclk),
    .sys_rst_n (sys_rst_n),
    .sfp_in    (sfp_in.snk),
    .eth_out   (eth_out.src)
  );

endmodule

`default_nettype wire

// ==== design/por_reset_gen.sv ====
/*
 * power-up reset generator
 * counts once the clock manager has locked and then releases the
 * link reset, which stays released until lock is lost
 */
`default_nettype none

module por_reset_gen import ctrl_pkg::*; (
  input  logic dclk,
  input  logic sys_rst_n,
  input  logic locked,      // clock manager lock
  output logic link_rst_n   // link reset, low active
);

  logic [RST_CNT_W-1:0] rst_cnt;  // cycles since lock

  // saturating counter, parks once the top bit is set
  always_ff @(posedge dclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rst_cnt <= '0;
    end else if (!locked) begin
      rst_cnt <= '0;                    // restart on loss of lock
    end else if (!rst_cnt[RST_CNT_W-1]) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  // release point, held until lock drops
  always_ff @(posedge dclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      link_rst_n <= 1'b0;
    end else if (!locked) begin
      link_rst_n <= 1'b0;
    end else if (rst_cnt > RST_RELEASE_COUNT) begin
      link_rst_n <= 1'b1;               // count has passed release
    end
  end

endmodule

`default_nettype wire

// ==== design/rx_link_watchdog.sv ====
/*
 * receive datapath watchdog
 * pulses the transceiver rx datapath reset after each wait period
 * until the link reports good status, then watches for status loss
 */
`default_nettype none

module rx_link_watchdog import ctrl_pkg::*; (
  input  logic dclk,
  input  logic sys_rst_n,
  input  logic link_rst_n,        // link held in reset while low
  input  logic stat_rx_status,    // rx link up
  output logic rx_datapath_reset  // one-cycle pulse
);

  logic [WD_ST_W-1:0]  wd_state;
  logic [WD_CNT_W-1:0] wd_cnt;    // shared by both wait states

  //******************************
  // watchdog FSM
  //******************************
  always_ff @(posedge dclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wd_state          <= WD_ST_WAIT;
      wd_cnt            <= '0;
      rx_datapath_reset <= 1'b0;
    end else if (!link_rst_n) begin
      // parked in wait until the link reset lifts
      wd_state          <= WD_ST_WAIT;
      wd_cnt            <= '0;
      rx_datapath_reset <= 1'b0;
    end else begin
      // pulse follows the pulse state by one cycle
      rx_datapath_reset <= (wd_state == WD_ST_PULSE);
      case (wd_state)
        WD_ST_WAIT: begin
          if (wd_cnt == WD_WAIT_CYCLES) begin
            wd_cnt   <= '0;
            wd_state <= WD_ST_PULSE;
          end else begin
            wd_cnt <= wd_cnt + 1'b1;
          end
        end
        WD_ST_PULSE: begin
          if (!stat_rx_status) begin
            wd_state <= WD_ST_RETRY;   // still down, try again
          end else begin
            wd_state <= WD_ST_SETTLE;
          end
        end
        WD_ST_RETRY:  wd_state <= WD_ST_WAIT;
        WD_ST_SETTLE: wd_state <= WD_ST_REWAIT;
        WD_ST_REWAIT: begin
          // one more full wait before trusting the status
          if (wd_cnt == WD_WAIT_CYCLES) begin
            wd_cnt   <= '0;
            wd_state <= WD_ST_MONITOR;
          end else begin
            wd_cnt <= wd_cnt + 1'b1;
          end
        end
        WD_ST_MONITOR: begin
          if (!stat_rx_status) begin
            wd_state <= WD_ST_PULSE;   // link lost
          end
        end
        default: wd_state <= WD_ST_WAIT;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/rx_type_dispatch.sv ====
/*
 * receive dispatcher
 * registers SFP beats whose type field marks ethernet onto the
 * ethernet output, drops every other type
 */
`default_nettype none

module rx_type_dispatch import stream_pkg::*; (
  input  logic dclk,
  input  logic sys_rst_n,
  beat_if.snk  sfp_in,
  beat_if.src  eth_out
);

  logic [TYPE_W-1:0] beat_type;
  logic              is_eth;      // valid ethernet beat this cycle

  assign beat_type = sfp_in.data[TYPE_LSB +: TYPE_W];
  assign is_eth    = sfp_in.valid && (beat_type == TYPE_ETH);

  // strobe, one cycle behind the input
  always_ff @(posedge dclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      eth_out.valid <= 1'b0;
    end else begin
      eth_out.valid <= is_eth;
    end
  end

  // payload only moves on a matching beat
  always_ff @(posedge dclk) begin
    if (is_eth) begin
      eth_out.data <= sfp_in.data;
      eth_out.last <= sfp_in.last;
      eth_out.keep <= sfp_in.keep;
    end
  end

endmodule

`default_nettype wire

// ==== design/stream_pkg.sv ====
/*
 * stream beat format
 * widths of one 64-bit beat, position of the type field in the low byte,
 * type codes and the byte enable of the idle node beat
 */
`default_nettype none

package stream_pkg;

  //******************************
  // beat geometry
  //******************************
  localparam int DATA_W = 64;   // beat data width
  localparam int KEEP_W = 8;    // one enable per data byte

  // type field sits in the upper nibble of byte 0
  localparam int TYPE_LSB = 4;
  localparam int TYPE_W   = 4;

  //******************************
  // type codes
  //******************************
  localparam logic [TYPE_W-1:0] TYPE_ETH  = 4'h1;  // ethernet traffic
  localparam logic [KEEP_W-1:0] IDLE_KEEP = 8'h01; // idle beat carries one byte

endpackage

`default_nettype wire

// ==== design/tx_node_mux.sv ====
/*
 * transmit node mux
 * stages ethernet beats and forwards them to the SFP stream when the
 * ethernet slot is enabled, sends an idle node beat when no slot is
 */
`default_nettype none

module tx_node_mux
  import stream_pkg::*;
  import ctrl_pkg::*;
(
  input  logic              dclk,
  input  logic              sys_rst_n,
  input  logic [NODE_W-1:0] node_info,  // {node id, slot mask}, static
  beat_if.snk               eth_in,
  beat_if.src               sfp_out
);

  logic [SLOT_W-1:0] slot_mask;
  logic              idle_mode;   // no slot enabled at all
  logic              fwd_en;      // staged beat goes out this edge
  logic [DATA_W-1:0] idle_data;

  // stage
  logic              stg_valid;
  logic [DATA_W-1:0] stg_data;
  logic              stg_last;
  logic [KEEP_W-1:0] stg_keep;

  assign slot_mask = node_info[SLOT_W-1:0];
  assign idle_mode = (slot_mask == '0);
  assign fwd_en    = slot_mask[ETH_SLOT] & stg_valid;

  // idle beat, node id in the type nibble, rest zero
  always_comb begin
    idle_data = '0;
    idle_data[NODE_ID_LSB +: NODE_W-NODE_ID_LSB] = node_info[NODE_W-1:NODE_ID_LSB];
  end

  //******************************
  // ethernet stage
  //******************************
  always_ff @(posedge dclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stg_valid <= 1'b0;
    end else if (eth_in.valid) begin
      stg_valid <= 1'b1;    // new capture beats the clear
    end else begin
      stg_valid <= 1'b0;    // forwarded, or dropped with slot off
    end
  end

  always_ff @(posedge dclk) begin
    if (eth_in.valid) begin
      stg_data <= eth_in.data;
      stg_last <= eth_in.last;
      stg_keep <= eth_in.keep;
    end
  end

  //******************************
  // output register
  //******************************
  always_ff @(posedge dclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sfp_out.valid <= 1'b0;
    end else begin
      sfp_out.valid <= idle_mode | fwd_en;  // idle is valid every cycle
    end
  end

  always_ff @(posedge dclk) begin
    if (idle_mode) begin
      sfp_out.data <= idle_data;
      sfp_out.last <= 1'b0;
      sfp_out.keep <= IDLE_KEEP;
    end else if (fwd_en) begin
      sfp_out.data <= stg_data;   // beat passes unchanged
      sfp_out.last <= stg_last;
      sfp_out.keep <= stg_keep;
    end
  end

endmodule

`default_nettype wire

// ==== tb/ht_top_tb.sv ====
/*
 * testbench for the hybrid transport node control top level
 * reset release, rx watchdog retries, ethernet forwarding, idle beat,
 * disabled slot and receive dispatch, checked by concurrent assertions
 */
`default_nettype none

module ht_top_tb
  import stream_pkg::*;
  import ctrl_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int BEAT_W      = DATA_W + KEEP_W + 1;  // {data, keep, last}
  localparam int PULSE_GAP   = WD_WAIT_CYCLES + 3;   // wait, pulse, retry
  localparam int MON_CYCLES  = 200;
  localparam int FWD_CYCLES  = 150;
  localparam int IDLE_CYCLES = 40;
  localparam int OFF_CYCLES  = 80;
  localparam int RX_CYCLES   = 150;
  // link release and five watchdog periods, then the stream phases
  localparam int RUN_CYCLES  = 100 + 5 * PULSE_GAP + MON_CYCLES + FWD_CYCLES +
                               IDLE_CYCLES + OFF_CYCLES + RX_CYCLES + 200;

  logic              dclk;
  logic              sys_rst_n;
  logic              locked;
  logic              stat_rx_status;
  logic [NODE_W-1:0] node_info;
  logic              eth_in_valid;
  logic [DATA_W-1:0] eth_in_data;
  logic              eth_in_last;
  logic [KEEP_W-1:0] eth_in_keep;
  logic              sfp_in_valid;
  logic [DATA_W-1:0] sfp_in_data;
  logic              sfp_in_last;
  logic [KEEP_W-1:0] sfp_in_keep;
  logic              link_rst_n;
  logic              rx_datapath_reset;
  logic              sfp_out_valid;
  logic [DATA_W-1:0] sfp_out_data;
  logic              sfp_out_last;
  logic [KEEP_W-1:0] sfp_out_keep;
  logic              eth_out_valid;
  logic [DATA_W-1:0] eth_out_data;
  logic              eth_out_last;
  logic [KEEP_W-1:0] eth_out_keep;

  integer            seed;
  int                errors = 0;
  string             test_name;
  logic              after_reset;     // window right after first release
  int                lock_cnt;        // edges seen with locked high
  int                pulse_gap;       // cycles since last datapath pulse
  int                pulse_cnt;
  logic              pulse_seen;
  logic              link_good;       // pulse seen with status up
  logic [BEAT_W:0]   fwd_q[$];        // {valid, beat}, one entry per cycle
  logic              exp_sfp_valid;
  logic [BEAT_W-1:0] exp_sfp_beat;
  logic              exp_eth_valid;
  logic [BEAT_W-1:0] exp_eth_beat;

  ht_top ht_top_inst (.*);

  initial begin
    dclk = 1'b0;
    forever #(CLK_PERIOD / 2) dclk = ~dclk;
  end

  function automatic logic [DATA_W-1:0] idle_beat_data(input logic [NODE_W-1:0] info);
    return DATA_W'(info[NODE_W-1:NODE_ID_LSB]) << NODE_ID_LSB;  // node id only
  endfunction

  //******************************
  // reference model
  //******************************
  always @(posedge dclk) begin
    if (!sys_rst_n) begin
      fwd_q.delete();
      exp_sfp_valid = 1'b0;
      exp_eth_valid = 1'b0;
    end else begin
      fwd_q.push_back({eth_in_valid, eth_in_data, eth_in_keep, eth_in_last});
      if (fwd_q.size() > 2) begin
        void'(fwd_q.pop_front());   // two-cycle delay line
      end
      if (node_info[SLOT_W-1:0] == '0) begin
        exp_sfp_valid = 1'b1;       // idle beat every cycle
        exp_sfp_beat  = {idle_beat_data(node_info), IDLE_KEEP, 1'b0};
      end else if (!node_info[ETH_SLOT] || fwd_q.size() < 2) begin
        exp_sfp_valid = 1'b0;
      end else begin
        {exp_sfp_valid, exp_sfp_beat} = fwd_q[0];
      end
      exp_eth_valid = sfp_in_valid && (sfp_in_data[TYPE_LSB +: TYPE_W] == TYPE_ETH);
      exp_eth_beat  = {sfp_in_data, sfp_in_keep, sfp_in_last};
    end
  end

  // lock and watchdog pulse bookkeeping
  always @(posedge dclk) begin
    lock_cnt = locked ? lock_cnt + 1 : 0;
    if (!sys_rst_n) begin
      pulse_seen = 1'b0;
      link_good  = 1'b0;
      pulse_gap  = 0;
      pulse_cnt  = 0;
    end else if (rx_datapath_reset) begin
      pulse_seen = 1'b1;
      pulse_gap  = 1;
      pulse_cnt++;
      if (stat_rx_status) begin
        link_good = 1'b1;
      end
    end else begin
      pulse_gap++;
    end
  end

  //******************************
  // checks
  //******************************
  a_reset_low: assert property (@(posedge dclk) after_reset |->
      {sfp_out_valid, eth_out_valid, rx_datapath_reset, link_rst_n} == 4'b0000)
    else begin
      errors++;
      $display("FAIL %s: outputs expected %b actual %b", test_name, 4'b0000,
               $sampled({sfp_out_valid, eth_out_valid, rx_datapath_reset, link_rst_n}));
    end

  a_link_held: assert property (@(posedge dclk) !locked |-> !link_rst_n)
    else begin
      errors++;
      $display("FAIL %s: link_rst_n expected 0 actual 1 while unlocked", test_name);
    end

  a_link_release: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      $rose(link_rst_n) |-> lock_cnt >= RST_RELEASE_COUNT)
    else begin
      errors++;
      $display("FAIL %s: lock cycles at release expected >= %0d actual %0d",
               test_name, RST_RELEASE_COUNT, $sampled(lock_cnt));
    end

  a_pulse_width: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      rx_datapath_reset |=> !rx_datapath_reset)
    else begin
      errors++;
      $display("FAIL %s: rx_datapath_reset stayed high for more than a cycle", test_name);
    end

  a_pulse_gap: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      (rx_datapath_reset && pulse_seen) |-> pulse_gap == PULSE_GAP)
    else begin
      errors++;
      $display("FAIL %s: pulse spacing expected %0d actual %0d", test_name, PULSE_GAP,
               $sampled(pulse_gap));
    end

  a_no_pulse: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      link_good |-> !rx_datapath_reset)
    else begin
      errors++;
      $display("FAIL %s: rx_datapath_reset pulsed while status held high", test_name);
    end

  a_sfp_valid: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      sfp_out_valid == exp_sfp_valid)
    else begin
      errors++;
      $display("FAIL %s: sfp_out_valid expected %0b actual %0b", test_name,
               $sampled(exp_sfp_valid), $sampled(sfp_out_valid));
    end

  a_sfp_beat: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      exp_sfp_valid |-> {sfp_out_data, sfp_out_keep, sfp_out_last} == exp_sfp_beat)
    else begin
      errors++;
      $display("FAIL %s: sfp_out beat expected %h actual %h", test_name,
               $sampled(exp_sfp_beat), $sampled({sfp_out_data, sfp_out_keep, sfp_out_last}));
    end

  a_eth_valid: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      eth_out_valid == exp_eth_valid)
    else begin
      errors++;
      $display("FAIL %s: eth_out_valid expected %0b actual %0b", test_name,
               $sampled(exp_eth_valid), $sampled(eth_out_valid));
    end

  a_eth_beat: assert property (@(posedge dclk) disable iff (!sys_rst_n)
      exp_eth_valid |-> {eth_out_data, eth_out_keep, eth_out_last} == exp_eth_beat)
    else begin
      errors++;
      $display("FAIL %s: eth_out beat expected %h actual %h", test_name,
               $sampled(exp_eth_beat), $sampled({eth_out_data, eth_out_keep, eth_out_last}));
    end

  //******************************
  // stimulus helpers
  //******************************
  task automatic next_cycle();
    @(posedge dclk);
    #1;                             // drive just after the edge
  endtask

  task automatic pulse_reset(input logic [NODE_W-1:0] info);
    sys_rst_n = 1'b0;
    node_info = info;               // static outside reset
    repeat (2) next_cycle();
    sys_rst_n = 1'b1;
  endtask

  task automatic clear_eth_in();
    eth_in_valid = 1'b0;
    eth_in_data  = '0;
    eth_in_last  = 1'b0;
    eth_in_keep  = '0;
  endtask

  task automatic clear_sfp_in();
    sfp_in_valid = 1'b0;
    sfp_in_data  = '0;
    sfp_in_last  = 1'b0;
    sfp_in_keep  = '0;
  endtask

  task automatic send_random_eth();
    logic [31:0] r;
    r            = $random(seed);
    eth_in_valid = (r[10:9] != 2'b00);  // mostly back to back
    eth_in_data  = {$random(seed), $random(seed)};
    eth_in_keep  = r[KEEP_W-1:0];
    eth_in_last  = r[8];
  endtask

  task automatic send_random_sfp();
    logic [31:0] r;
    r            = $random(seed);
    sfp_in_valid = r[9];
    sfp_in_data  = {$random(seed), $random(seed)};
    if (r[10]) begin
      sfp_in_data[TYPE_LSB +: TYPE_W] = TYPE_ETH;  // about half ethernet
    end
    sfp_in_keep  = r[KEEP_W-1:0];
    sfp_in_last  = r[8];
  endtask

  //******************************
  // test sequence
  //******************************
  initial begin
    seed           = 32'h4f022ca5;
    after_reset    = 1'b0;
    test_name      = "reset_release";
    sys_rst_n      = 1'b0;
    locked         = 1'b0;
    stat_rx_status = 1'b0;
    node_info      = 8'h11;             // node 1, ethernet slot on
    clear_eth_in();
    clear_sfp_in();
    repeat (2) @(posedge dclk);
    #1;
    sys_rst_n   = 1'b1;
    after_reset = 1'b1;
    repeat (8) next_cycle();            // still unlocked
    after_reset = 1'b0;
    repeat (RST_RELEASE_COUNT) next_cycle();  // unlocked past the release count
    locked      = 1'b1;

    test_name = "datapath_retry";
    while (!link_rst_n) next_cycle();
    while (pulse_cnt < 3) next_cycle();
    stat_rx_status = 1'b1;              // link comes up
    while (!link_good) next_cycle();
    repeat (MON_CYCLES) next_cycle();

    test_name = "eth_forward";
    repeat (FWD_CYCLES) begin
      send_random_eth();
      next_cycle();
    end
    clear_eth_in();
    repeat (4) next_cycle();

    test_name = "idle_beat";
    pulse_reset(8'ha0);                 // node 10, no slot
    repeat (IDLE_CYCLES) next_cycle();

    test_name = "slot_disabled";
    pulse_reset(8'h12);                 // ethernet slot off
    repeat (OFF_CYCLES) begin
      send_random_eth();
      next_cycle();
    end
    clear_eth_in();

    test_name = "rx_dispatch";
    repeat (RX_CYCLES) begin
      send_random_sfp();
      next_cycle();
    end
    clear_sfp_in();
    repeat (3) next_cycle();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // run limit
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles, errors %0d", RUN_CYCLES,
             errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
